/* source/mips_pkg.sv */
`default_nettype none

package mips_pkg;

    localparam int data_w     = 32;
    localparam int reg_addr_w = 5;

    localparam logic [reg_addr_w-1:0] ra_reg      = 5'd31;  // $ra
    localparam logic [data_w-1:0]     link_offset = 32'd8;  // past the delay slot
    localparam logic [data_w-1:0]     nop_instr   = '0;     // sll $0, $0, 0

    // primary opcode field, instr[31:26]
    typedef enum logic [5:0] {
        op_special = 6'b000000,
        op_jal     = 6'b000011,
        op_beq     = 6'b000100,
        op_bne     = 6'b000101,
        op_addi    = 6'b001000,
        op_andi    = 6'b001100,
        op_ori     = 6'b001101,
        op_lui     = 6'b001111,
        op_lb      = 6'b100000,
        op_lh      = 6'b100001,
        op_lw      = 6'b100011,
        op_sb      = 6'b101000,
        op_sh      = 6'b101001,
        op_sw      = 6'b101011
    } opcode_e;

    // R-type function field, instr[5:0]
    typedef enum logic [5:0] {
        funct_sll  = 6'b000000,
        funct_jr   = 6'b001000,
        funct_add  = 6'b100000,
        funct_sub  = 6'b100010,
        funct_and  = 6'b100100,
        funct_or   = 6'b100101,
        funct_slt  = 6'b101010,
        funct_sltu = 6'b101011
    } funct_e;

    typedef enum logic [1:0] {
        wb_alu     = 2'd0,
        wb_mem     = 2'd1,
        wb_pc_link = 2'd2
    } wb_src_e;

    typedef enum logic [1:0] {
        ld_word = 2'd0,
        ld_byte = 2'd1,
        ld_half = 2'd2,
        ld_none = 2'd3
    } load_kind_e;

endpackage

`default_nettype wire

/* source/wb_stage_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface wb_stage_if;

    logic [mips_pkg::data_w-1:0] instr;
    logic [mips_pkg::data_w-1:0] pc;
    logic [mips_pkg::data_w-1:0] alu_out;  // also the load address
    logic [mips_pkg::data_w-1:0] dm_out;   // raw memory word

    modport source (
        output instr,
        output pc,
        output alu_out,
        output dm_out
    );

    modport sink (
        input instr,
        input pc,
        input alu_out,
        input dm_out
    );

endinterface

`default_nettype wire

/* source/m_w_reg.sv */
`timescale 1ns/100ps
`default_nettype none

module m_w_reg (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        stall,
    input  logic                        flush,
    input  logic [mips_pkg::data_w-1:0] m_instr,
    input  logic [mips_pkg::data_w-1:0] m_pc,
    input  logic [mips_pkg::data_w-1:0] m_alu_out,
    input  logic [mips_pkg::data_w-1:0] m_dm_out,
    wb_stage_if.source                  w
);

    // a bubble decodes as a write to $0, so nothing reaches the register file
    always_ff @(posedge clk) begin
        if (reset || flush) begin  // flush beats stall
            w.instr   <= mips_pkg::nop_instr;
            w.pc      <= '0;
            w.alu_out <= '0;
            w.dm_out  <= '0;
        end else if (!stall) begin
            w.instr   <= m_instr;
            w.pc      <= m_pc;
            w.alu_out <= m_alu_out;
            w.dm_out  <= m_dm_out;
        end
    end

endmodule

`default_nettype wire

/* source/cu_w.sv */
`timescale 1ns/100ps
`default_nettype none

module cu_w (
    wb_stage_if.sink                              w,
    output logic [mips_pkg::reg_addr_w-1:0]       reg_addr,
    output mips_pkg::wb_src_e                     wb_src,
    output mips_pkg::load_kind_e                  load_kind
);

    typedef enum logic [2:0] {
        cls_calc_r,
        cls_calc_i,
        cls_load,
        cls_store,
        cls_branch,
        cls_jump,   // jr
        cls_link,   // jal
        cls_other
    } instr_class_e;

    mips_pkg::opcode_e                op;
    mips_pkg::funct_e                 funct;
    logic [mips_pkg::reg_addr_w-1:0]  rt;
    logic [mips_pkg::reg_addr_w-1:0]  rd;
    instr_class_e                     iclass;

    assign op    = mips_pkg::opcode_e'(w.instr[31:26]);
    assign rt    = w.instr[20:16];
    assign rd    = w.instr[15:11];
    assign funct = mips_pkg::funct_e'(w.instr[5:0]);

    always_comb begin
        case (op)
            mips_pkg::op_special: begin
                case (funct)
                    mips_pkg::funct_add, mips_pkg::funct_sub,
                    mips_pkg::funct_and, mips_pkg::funct_or,
                    mips_pkg::funct_slt, mips_pkg::funct_sltu,
                    mips_pkg::funct_sll:  iclass = cls_calc_r;
                    mips_pkg::funct_jr:   iclass = cls_jump;
                    default:              iclass = cls_other;
                endcase
            end
            mips_pkg::op_ori, mips_pkg::op_andi,
            mips_pkg::op_addi, mips_pkg::op_lui:   iclass = cls_calc_i;
            mips_pkg::op_lw, mips_pkg::op_lb,
            mips_pkg::op_lh:                       iclass = cls_load;
            mips_pkg::op_sw, mips_pkg::op_sb,
            mips_pkg::op_sh:                       iclass = cls_store;
            mips_pkg::op_beq, mips_pkg::op_bne:    iclass = cls_branch;
            mips_pkg::op_jal:                      iclass = cls_link;
            default:                               iclass = cls_other;
        endcase
    end

    always_comb begin
        case (iclass)
            cls_calc_r: begin
                reg_addr = rd;
                wb_src   = mips_pkg::wb_alu;
            end
            cls_calc_i, cls_load: begin
                reg_addr = rt;
                wb_src   = (iclass == cls_load) ? mips_pkg::wb_mem : mips_pkg::wb_alu;
            end
            cls_link: begin
                reg_addr = mips_pkg::ra_reg;
                wb_src   = mips_pkg::wb_pc_link;
            end
            default: begin  // store, branch, jr: nothing to write
                reg_addr = '0;
                wb_src   = mips_pkg::wb_alu;
            end
        endcase
    end

    always_comb begin
        case (op)
            mips_pkg::op_lw: load_kind = mips_pkg::ld_word;
            mips_pkg::op_lb: load_kind = mips_pkg::ld_byte;
            mips_pkg::op_lh: load_kind = mips_pkg::ld_half;
            default:         load_kind = mips_pkg::ld_none;
        endcase
    end

endmodule

`default_nettype wire

/* source/wb_data_select.sv */
`timescale 1ns/100ps
`default_nettype none

module wb_data_select (
    wb_stage_if.sink                      w,
    input  mips_pkg::wb_src_e             wb_src,
    input  mips_pkg::load_kind_e          load_kind,
    output logic [mips_pkg::data_w-1:0]   wb_data
);

    logic [7:0]                  byte_lane;
    logic [15:0]                 half_lane;
    logic [mips_pkg::data_w-1:0] load_data;

    // little-endian lanes picked by the address low bits
    always_comb begin
        case (w.alu_out[1:0])
            2'd0:    byte_lane = w.dm_out[7:0];
            2'd1:    byte_lane = w.dm_out[15:8];
            2'd2:    byte_lane = w.dm_out[23:16];
            default: byte_lane = w.dm_out[31:24];
        endcase
    end

    assign half_lane = w.alu_out[1] ? w.dm_out[31:16] : w.dm_out[15:0];

    always_comb begin
        case (load_kind)
            mips_pkg::ld_byte: load_data = {{24{byte_lane[7]}}, byte_lane};
            mips_pkg::ld_half: load_data = {{16{half_lane[15]}}, half_lane};
            default:           load_data = w.dm_out;  // lw
        endcase
    end

    always_comb begin
        case (wb_src)
            mips_pkg::wb_mem:     wb_data = load_data;
            mips_pkg::wb_pc_link: wb_data = w.pc + mips_pkg::link_offset;
            default:              wb_data = w.alu_out;
        endcase
    end

endmodule

`default_nettype wire

/* source/reg_file.sv */
`timescale 1ns/100ps
`default_nettype none

module reg_file (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [mips_pkg::reg_addr_w-1:0] wr_addr,
    input  logic [mips_pkg::data_w-1:0]     wr_data,
    input  logic [mips_pkg::reg_addr_w-1:0] rd_addr_a,
    input  logic [mips_pkg::reg_addr_w-1:0] rd_addr_b,
    output logic [mips_pkg::data_w-1:0]     rd_data_a,
    output logic [mips_pkg::data_w-1:0]     rd_data_b
);

    localparam int depth = 2 ** mips_pkg::reg_addr_w;

    logic [mips_pkg::data_w-1:0] regs [depth];

    // same-cycle write shows through, $0 always zero
    function automatic logic [mips_pkg::data_w-1:0] read_port(
        input logic [mips_pkg::reg_addr_w-1:0] addr
    );
        logic [mips_pkg::data_w-1:0] value;
        if (addr == '0)
            value = '0;
        else if (addr == wr_addr)
            value = wr_data;  // bypass
        else
            value = regs[addr];
        return value;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < depth; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    always_comb begin
        rd_data_a = read_port(rd_addr_a);
    end

    always_comb begin
        rd_data_b = read_port(rd_addr_b);
    end

endmodule

`default_nettype wire

/* source/wb_top.sv */
`timescale 1ns/100ps
`default_nettype none

module wb_top (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            stall,
    input  logic                            flush,
    input  logic [mips_pkg::data_w-1:0]     m_instr,
    input  logic [mips_pkg::data_w-1:0]     m_pc,
    input  logic [mips_pkg::data_w-1:0]     m_alu_out,
    input  logic [mips_pkg::data_w-1:0]     m_dm_out,
    input  logic [mips_pkg::reg_addr_w-1:0] rs_addr,
    input  logic [mips_pkg::reg_addr_w-1:0] rt_addr,
    output logic [mips_pkg::data_w-1:0]     rs_data,
    output logic [mips_pkg::data_w-1:0]     rt_data,
    output logic [mips_pkg::reg_addr_w-1:0] w_fwd_addr,
    output logic [mips_pkg::data_w-1:0]     w_fwd_data
);

    wb_stage_if w_stage ();

    mips_pkg::wb_src_e    wb_src;
    mips_pkg::load_kind_e load_kind;

    m_w_reg u_m_w_reg (
        .clk       (clk),
        .reset     (reset),
        .stall     (stall),
        .flush     (flush),
        .m_instr   (m_instr),
        .m_pc      (m_pc),
        .m_alu_out (m_alu_out),
        .m_dm_out  (m_dm_out),
        .w         (w_stage.source)
    );

    // destination doubles as the forwarding address, zero when idle
    cu_w u_cu_w (
        .w         (w_stage.sink),
        .reg_addr  (w_fwd_addr),
        .wb_src    (wb_src),
        .load_kind (load_kind)
    );

    wb_data_select u_wb_data_select (
        .w         (w_stage.sink),
        .wb_src    (wb_src),
        .load_kind (load_kind),
        .wb_data   (w_fwd_data)
    );

    reg_file u_reg_file (
        .clk       (clk),
        .reset     (reset),
        .wr_addr   (w_fwd_addr),
        .wr_data   (w_fwd_data),
        .rd_addr_a (rs_addr),
        .rd_addr_b (rt_addr),
        .rd_data_a (rs_data),
        .rd_data_b (rt_data)
    );

endmodule

`default_nettype wire

/* testbench/wb_properties.sv */
`timescale 1ns/100ps
`default_nettype none

module wb_properties (
    input  logic        clk,
    input  logic        reset,
    input  logic        stall,
    input  logic        flush,
    input  logic [4:0]  rs_addr,
    input  logic [4:0]  rt_addr,
    input  logic [31:0] rs_data,
    input  logic [31:0] rt_data,
    input  logic [4:0]  w_fwd_addr,
    input  logic [31:0] w_fwd_data
);

    int fail_count = 0;  // read by the testbench at the end

    idle_after_clear: assert property (
        @(posedge clk) (reset || flush) |=> (w_fwd_addr == '0)
    ) else begin
        fail_count++;
        $error("w_fwd_addr not zero after reset or flush");
    end

    // held W state keeps the forwarding outputs still
    hold_on_stall: assert property (
        @(posedge clk) disable iff (reset)
        (stall && !flush) |=> ($stable(w_fwd_addr) && $stable(w_fwd_data))
    ) else begin
        fail_count++;
        $error("forwarding outputs changed across a stall");
    end

    zero_read_a: assert property (
        @(posedge clk) (rs_addr == '0) |-> (rs_data == '0)
    ) else begin
        fail_count++;
        $error("rs port returned nonzero for $0");
    end

    zero_read_b: assert property (
        @(posedge clk) (rt_addr == '0) |-> (rt_data == '0)
    ) else begin
        fail_count++;
        $error("rt port returned nonzero for $0");
    end

endmodule

bind wb_top wb_properties props (
    .clk        (clk),
    .reset      (reset),
    .stall      (stall),
    .flush      (flush),
    .rs_addr    (rs_addr),
    .rt_addr    (rt_addr),
    .rs_data    (rs_data),
    .rt_data    (rt_data),
    .w_fwd_addr (w_fwd_addr),
    .w_fwd_data (w_fwd_data)
);

`default_nettype wire

/* testbench/wb_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module wb_tb;

    localparam int period     = 100;
    localparam int num_calc   = 60;  // half calc-R, half calc-I
    localparam int num_load   = 20;
    localparam int num_misc   = 30;  // jal, no-write, stall/flush, bypass
    localparam int num_sweeps = 3;
    localparam int watchdog_cycles =
        (3 + num_calc + num_load + num_misc + 33 * num_sweeps) * 2;

    logic        clk;
    logic        reset;
    logic        stall;
    logic        flush;
    logic [31:0] m_instr;
    logic [31:0] m_pc;
    logic [31:0] m_alu_out;
    logic [31:0] m_dm_out;
    logic [4:0]  rs_addr;
    logic [4:0]  rt_addr;
    logic [31:0] rs_data;
    logic [31:0] rt_data;
    logic [4:0]  w_fwd_addr;
    logic [31:0] w_fwd_data;

    logic [31:0] model [32];
    logic [4:0]  pend_addr;  // what the W stage should show now
    logic [31:0] pend_data;
    int          errors;
    integer      seed = 1;

    wb_top dut (
        .clk        (clk),
        .reset      (reset),
        .stall      (stall),
        .flush      (flush),
        .m_instr    (m_instr),
        .m_pc       (m_pc),
        .m_alu_out  (m_alu_out),
        .m_dm_out   (m_dm_out),
        .rs_addr    (rs_addr),
        .rt_addr    (rt_addr),
        .rs_data    (rs_data),
        .rt_data    (rt_data),
        .w_fwd_addr (w_fwd_addr),
        .w_fwd_data (w_fwd_data)
    );

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    function automatic int pick(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic logic [31:0] r_type(input logic [5:0] funct, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [4:0] rd);
        return {6'b000000, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic logic [31:0] i_type(input logic [5:0] op, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [5:0] calc_funct(input int k);
        case (k)
            0:       return mips_pkg::funct_add;
            1:       return mips_pkg::funct_sub;
            2:       return mips_pkg::funct_and;
            3:       return mips_pkg::funct_or;
            4:       return mips_pkg::funct_slt;
            5:       return mips_pkg::funct_sltu;
            default: return mips_pkg::funct_sll;
        endcase
    endfunction

    function automatic logic [5:0] calc_i_op(input int k);
        case (k)
            0:       return mips_pkg::op_ori;
            1:       return mips_pkg::op_andi;
            2:       return mips_pkg::op_addi;
            default: return mips_pkg::op_lui;
        endcase
    endfunction

    // register read as seen through the write bypass
    function automatic logic [31:0] expected_read(input logic [4:0] addr);
        if (addr == 5'd0)
            return 32'd0;
        if (addr == pend_addr)
            return pend_data;
        return model[addr];
    endfunction

    task automatic check_read(input logic [4:0] addr, input logic [31:0] data,
                              input string port);
        logic [31:0] exp_data;
        exp_data = expected_read(addr);
        assert (data == exp_data) else begin
            errors++;
            $display("ERROR %0t: %s read of $%0d gave %h, expected %h",
                     $time, port, addr, data, exp_data);
        end
    endtask

    task automatic check_w_stage();
        assert (w_fwd_addr == pend_addr) else begin
            errors++;
            $display("ERROR %0t: w_fwd_addr %0d, expected %0d", $time, w_fwd_addr, pend_addr);
        end
        if (pend_addr != 5'd0) begin
            assert (w_fwd_data == pend_data) else begin
                errors++;
                $display("ERROR %0t: w_fwd_data %h, expected %h", $time, w_fwd_data, pend_data);
            end
        end
        check_read(rs_addr, rs_data, "rs");
        check_read(rt_addr, rt_data, "rt");
    endtask

    // one M-stage issue; checks the W state left by the previous issue
    task automatic drive_cycle(input logic [31:0] instr, input logic [31:0] pc,
                               input logic [31:0] alu, input logic [31:0] dm,
                               input logic st, input logic fl,
                               input logic [4:0] e_addr, input logic [31:0] e_data);
        @(posedge clk);
        m_instr   <= instr;
        m_pc      <= pc;
        m_alu_out <= alu;
        m_dm_out  <= dm;
        stall     <= st;
        flush     <= fl;
        rs_addr   <= pend_addr;  // same-cycle bypass on both ports
        rt_addr   <= pend_addr;
        @(negedge clk);
        check_w_stage();
        if (pend_addr != 5'd0)
            model[pend_addr] = pend_data;
        if (fl) begin
            pend_addr = 5'd0;
            pend_data = 32'd0;
        end else if (!st) begin
            pend_addr = e_addr;
            pend_data = e_data;
        end
    endtask

    task automatic issue_no_write(input logic [31:0] instr);
        drive_cycle(instr, rand_word(), rand_word(), rand_word(), 1'b0, 1'b0, 5'd0, 32'd0);
    endtask

    task automatic sweep_regs();
        drive_cycle(32'd0, 32'd0, 32'd0, 32'd0, 1'b0, 1'b0, 5'd0, 32'd0);  // bubble
        for (int i = 0; i < 32; i++) begin
            @(posedge clk);
            rs_addr <= 5'(i);
            rt_addr <= 5'(31 - i);
            @(negedge clk);
            check_read(rs_addr, rs_data, "rs");
            check_read(rt_addr, rt_data, "rt");
        end
    endtask

    initial begin
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [31:0] alu;
        logic [31:0] dm;
        logic [31:0] pc;
        logic [31:0] lane;
        errors    = 0;
        reset     = 1'b1;
        stall     = 1'b0;
        flush     = 1'b0;
        m_instr   = 32'd0;
        m_pc      = 32'd0;
        m_alu_out = 32'd0;
        m_dm_out  = 32'd0;
        rs_addr   = 5'd0;
        rt_addr   = 5'd0;
        pend_addr = 5'd0;
        pend_data = 32'd0;
        for (int i = 0; i < 32; i++)
            model[i] = 32'd0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        sweep_regs();

        for (int n = 0; n < num_calc; n++) begin
            rt  = 5'(rand_word());
            rd  = 5'(rand_word());
            alu = rand_word();
            if (n % 2 == 0)
                drive_cycle(r_type(calc_funct(pick(7)), 5'(rand_word()), rt, rd),
                            rand_word(), alu, rand_word(), 1'b0, 1'b0, rd, alu);
            else
                drive_cycle(i_type(calc_i_op(pick(4)), 5'(rand_word()), rt, 16'(rand_word())),
                            rand_word(), alu, rand_word(), 1'b0, 1'b0, rt, alu);
        end

        for (int k = 0; k < 4; k++) begin  // lw
            rt  = 5'(rand_word());
            dm  = rand_word();
            alu = (rand_word() & ~32'd3) | 32'(k);
            drive_cycle(i_type(mips_pkg::op_lw, 5'd2, rt, 16'(alu)), rand_word(), alu, dm,
                        1'b0, 1'b0, rt, dm);
        end
        for (int k = 0; k < 8; k++) begin  // lb, each lane, both signs
            rt  = 5'(rand_word());
            dm  = rand_word();
            dm[8 * (k / 2) + 7] = k[0];
            alu  = (rand_word() & ~32'd3) | 32'(k / 2);
            lane = dm >> (8 * (k / 2));
            drive_cycle(i_type(mips_pkg::op_lb, 5'd2, rt, 16'(alu)), rand_word(), alu, dm,
                        1'b0, 1'b0, rt, {{24{lane[7]}}, lane[7:0]});
        end
        for (int k = 0; k < 8; k++) begin  // lh, bit 1 of the address picks the half
            rt  = 5'(rand_word());
            dm  = rand_word();
            dm[16 * (k / 4) + 15] = k[0];
            alu  = (rand_word() & ~32'd3) | 32'(k / 2);
            lane = dm >> (16 * (k / 4));
            drive_cycle(i_type(mips_pkg::op_lh, 5'd2, rt, 16'(alu)), rand_word(), alu, dm,
                        1'b0, 1'b0, rt, {{16{lane[15]}}, lane[15:0]});
        end

        for (int k = 0; k < 4; k++) begin  // jal
            pc = rand_word() & ~32'd3;
            drive_cycle({mips_pkg::op_jal, 26'(rand_word())}, pc, rand_word(), rand_word(),
                        1'b0, 1'b0, 5'd31, pc + 32'd8);
        end
        sweep_regs();

        issue_no_write(i_type(mips_pkg::op_sw, 5'd3, 5'd4, 16'h0010));
        issue_no_write(i_type(mips_pkg::op_sb, 5'd3, 5'd6, 16'h0011));
        issue_no_write(i_type(mips_pkg::op_sh, 5'd3, 5'd8, 16'h0012));
        issue_no_write(i_type(mips_pkg::op_beq, 5'd1, 5'd10, 16'hfff0));
        issue_no_write(i_type(mips_pkg::op_bne, 5'd1, 5'd11, 16'h0008));
        issue_no_write(r_type(mips_pkg::funct_jr, 5'd31, 5'd0, 5'd0));
        issue_no_write(r_type(mips_pkg::funct_add, 5'd1, 5'd2, 5'd0));  // aimed at $0
        issue_no_write(i_type(mips_pkg::op_ori, 5'd1, 5'd0, 16'h00ff));
        issue_no_write(i_type(mips_pkg::op_lw, 5'd1, 5'd0, 16'h0004));

        alu = rand_word();
        drive_cycle(r_type(mips_pkg::funct_add, 5'd1, 5'd2, 5'd7), 32'h100, alu, 32'd0,
                    1'b0, 1'b0, 5'd7, alu);
        drive_cycle(i_type(mips_pkg::op_ori, 5'd1, 5'd9, 16'h1234), 32'h104, rand_word(),
                    32'd0, 1'b1, 1'b0, 5'd9, 32'd0);  // dropped, W holds $7
        drive_cycle(r_type(mips_pkg::funct_or, 5'd1, 5'd2, 5'd12), 32'h108, rand_word(),
                    32'd0, 1'b1, 1'b0, 5'd12, 32'd0);
        alu = rand_word();
        drive_cycle(i_type(mips_pkg::op_lui, 5'd0, 5'd13, 16'h00ab), 32'h10c, alu, 32'd0,
                    1'b0, 1'b0, 5'd13, alu);
        drive_cycle(r_type(mips_pkg::funct_add, 5'd1, 5'd2, 5'd14), 32'h110, rand_word(),
                    32'd0, 1'b0, 1'b1, 5'd14, 32'd0);
        drive_cycle(r_type(mips_pkg::funct_add, 5'd1, 5'd2, 5'd15), 32'h114, rand_word(),
                    32'd0, 1'b1, 1'b1, 5'd15, 32'd0);  // flush beats stall
        drive_cycle(r_type(mips_pkg::funct_add, 5'd1, 5'd2, 5'd15), 32'h118, rand_word(),
                    32'd0, 1'b1, 1'b0, 5'd15, 32'd0);  // stall on a bubble

        for (int k = 0; k < 4; k++) begin  // back-to-back writes to $5
            alu = rand_word();
            drive_cycle(r_type(mips_pkg::funct_or, 5'd3, 5'd4, 5'd5), rand_word(), alu,
                        32'd0, 1'b0, 1'b0, 5'd5, alu);
        end
        sweep_regs();

        @(negedge clk);
        $display("errors: %0d from checks, %0d from assertions", errors, dut.props.fail_count);
        if (errors == 0 && dut.props.fail_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin
        #(watchdog_cycles * period);
        $display("timeout: run did not finish within %0d cycles", watchdog_cycles);
        $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
source/mips_pkg.sv
source/wb_stage_if.sv
source/m_w_reg.sv
source/cu_w.sv
source/wb_data_select.sv
source/reg_file.sv
source/wb_top.sv
testbench/wb_properties.sv
testbench/wb_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= wb_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only -Wall --timing
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= all tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the simulation passes only if the pass message shows up as a line of its own
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
